//--- hw/progress_pkg.sv
/*
 * Progress controller shared definitions
 * Bus widths, region and byte-select codes, acknowledge FSM state
 */
`default_nettype none

package progress_pkg;

   typedef logic [31:0] addr_t;      // Bus address, from ALU B operand
   typedef logic [3:0]  bytesel_t;   // One bit per byte lane
   typedef logic [3:0]  wsel_t;      // Microcode write width field
   typedef logic [3:0]  region_t;    // Top address nibble

   // Write width codes from microcode
   localparam wsel_t WSEL_HALF = 4'b0001;
   localparam wsel_t WSEL_BYTE = 4'b0010;

   // Control registers live at 0x2xxxxxxx
   localparam region_t REGION_CTRLREG = 4'b0010;

   // Lane patterns
   localparam bytesel_t SEL_ALL  = 4'b1111;
   localparam bytesel_t SEL_NONE = 4'b0000;

   // Acknowledge qualification, see Wishbone rule 3.55
   typedef enum logic {
      ACK_NORMAL = 1'b0,   // Normal operation
      ACK_R355   = 1'b1    // Ack seen without strobe, slave holds it high
   } ack_state_t;

endpackage

`default_nettype wire

//--- hw/access_if.sv
/*
 * Access decode bundle
 * Region hits and alignment status from decode to the bus cycle logic
 */
`timescale 1ns/1ps
`default_nettype none

interface access_if;

   logic io_hit;       // Address in I/O region
   logic sram_hit;     // Address in SRAM region
   logic ctrlreg_hit;  // Address in control register space
   logic bad_align;    // Core stopped or misaligned word store

   // Decode side produces, bus cycle side consumes
   modport decode (output io_hit, sram_hit, ctrlreg_hit, bad_align);
   modport cycle  (input  io_hit, sram_hit, ctrlreg_hit, bad_align);

endinterface

`default_nettype wire

//--- hw/access_decode.sv
/*
 * Access decode
 * Address region and alignment decode, registered byte selects and mask
 */
`timescale 1ns/1ps
`default_nettype none

module access_decode (
   input  wire                  clk,
   input  wire                  RST_I,
   input  wire                  core_running,  // Block bus writes while stopped
   input  progress_pkg::addr_t  addr,          // ALU B operand
   input  progress_pkg::wsel_t  wsel,          // Write width from microcode
   input  wire                  sel_latch,     // Capture byte selects
   input  wire                  word_store,    // SW must be word aligned
   output progress_pkg::bytesel_t byte_sel,    // Lanes for SRAM and I/O
   output progress_pkg::bytesel_t byte_mask,   // Active low lanes for register file
   access_if.decode             acc
);
   import progress_pkg::*;

   region_t  region;
   bytesel_t sel_next;

   assign region = addr[31:28];

   // Region decode
   assign acc.io_hit      = ~addr[31] & addr[30];        // 0x4xxxxxxx to 0x7xxxxxxx
   assign acc.sram_hit    = addr[31];                    // Upper half of map
   assign acc.ctrlreg_hit = (region == REGION_CTRLREG);

   // No strobe or write before the core runs, nor for a SW off a word boundary
   assign acc.bad_align = ~core_running | (word_store & (|addr[1:0]));

   // Lane pattern from width and low address bits
   always_comb begin
      sel_next = SEL_ALL;                                // Word and unknown codes
      if (wsel == WSEL_HALF) begin
         case (addr[1:0])
            2'b00:   sel_next = 4'b0011;                 // Low halfword
            2'b10:   sel_next = 4'b1100;                 // High halfword
            default: sel_next = SEL_ALL;
         endcase
      end else if (wsel == WSEL_BYTE) begin
         sel_next = bytesel_t'(4'b0001 << addr[1:0]);    // One-hot lane
      end
   end

   // Byte selects and their complement, held until next latch
   always_ff @(posedge clk) begin
      if (RST_I) begin
         byte_sel  <= SEL_NONE;
         byte_mask <= SEL_ALL;
      end else if (sel_latch) begin
         byte_sel  <= sel_next;
         byte_mask <= ~sel_next;
      end
   end

endmodule

`default_nettype wire

//--- hw/ack_qualify.sv
/*
 * Acknowledge qualifier
 * Tolerates a slave that holds its acknowledge high (Wishbone rule 3.55)
 */
`timescale 1ns/1ps
`default_nettype none

module ack_qualify (
   input  wire  clk,
   input  wire  RST_I,
   input  wire  bus_ack,     // Raw I/O acknowledge
   input  wire  sysreg_ack,  // System register acknowledge, always trusted
   input  wire  bus_stb,     // Our I/O strobe
   output logic qack         // Qualified acknowledge, same cycle
);
   import progress_pkg::*;

   ack_state_t state;
   ack_state_t state_next;

   always_comb begin
      state_next = state;
      qack       = sysreg_ack;
      case (state)
         ACK_NORMAL: begin
            qack = sysreg_ack | (bus_ack & bus_stb);
            if (bus_ack & ~bus_stb)
               state_next = ACK_R355;   // Ack without strobe, assume held ack
         end
         ACK_R355: begin
            // Ack is meaningless here, the strobe acknowledges itself
            qack = sysreg_ack | bus_stb;
            if (~bus_ack)
               state_next = ACK_NORMAL; // Slave released it
         end
         default: state_next = ACK_NORMAL;
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I)
         state <= ACK_NORMAL;
      else
         state <= state_next;
   end

endmodule

`default_nettype wire

//--- hw/bus_cycle.sv
/*
 * Bus cycle control
 * I/O and SRAM strobes held until acknowledge, write enable registers
 */
`timescale 1ns/1ps
`default_nettype none

module bus_cycle (
   input  wire      clk,
   input  wire      RST_I,
   input  wire      bus_ack,      // I/O slave acknowledge
   input  wire      sysreg_ack,   // System register acknowledge
   input  wire      sram_ack,     // SRAM acknowledge
   input  wire      bus_error,    // Abort current access
   input  wire      stb_req,      // Microcode asks for a strobe
   input  wire      we_req,       // Microcode asks for a write enable
   input  wire      we_hold,      // Low drops the write enables
   access_if.cycle  acc,
   output logic     bus_stb,      // I/O strobe
   output logic     sram_stb,     // SRAM strobe
   output logic     bus_we,       // Write to I/O or SRAM
   output logic     ctrlreg_we,   // Write to control registers
   output logic     qack,         // Qualified I/O acknowledge
   output logic     bus_busy      // Some strobe is active
);
   logic bus_stb_next;
   logic sram_stb_next;
   logic bus_we_next;
   logic ctrlreg_we_next;

   ack_qualify u_ack_qualify (
      .clk        (clk),
      .RST_I      (RST_I),
      .bus_ack    (bus_ack),
      .sysreg_ack (sysreg_ack),
      .bus_stb    (bus_stb),
      .qack       (qack)
   );

   // Set on a good request, then hold until acknowledged
   assign bus_stb_next  = (stb_req & acc.io_hit & ~acc.bad_align)
                        | (bus_stb & ~qack);
   assign sram_stb_next = (stb_req & acc.sram_hit & ~acc.bad_align)
                        | (sram_stb & ~sram_ack);

   always_ff @(posedge clk) begin
      if (RST_I | bus_error) begin   // Error ends the access at once
         bus_stb  <= 1'b0;
         sram_stb <= 1'b0;
      end else begin
         bus_stb  <= bus_stb_next;
         sram_stb <= sram_stb_next;
      end
   end

   assign bus_busy = bus_stb | sram_stb;   // Stalls microcode

   // Write targets, misaligned SW gets no write at all
   assign bus_we_next     = (acc.io_hit | acc.sram_hit) & ~acc.bad_align;
   assign ctrlreg_we_next = acc.ctrlreg_hit & ~acc.bad_align;

   always_ff @(posedge clk) begin
      if (~we_hold | RST_I | bus_error) begin
         bus_we     <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (we_req) begin
         bus_we     <= bus_we_next;
         ctrlreg_we <= ctrlreg_we_next;
      end
   end

endmodule

`default_nettype wire

//--- hw/ucode_progress.sv
/*
 * Microcode progress
 * Stall, Q enable and register-file write enable from bus activity
 */
`timescale 1ns/1ps
`default_nettype none

module ucode_progress (
   input  wire  core_running,
   input  wire  bus_busy,       // Strobe outstanding
   input  wire  bus_we,         // External write under way
   input  wire  bus_error,      // Forces progress
   input  wire  q_load,         // Q enable term from microcode
   input  wire  q_read,         // Read input into Q
   input  wire  shift_repeat,   // Repeat shift until count done
   input  wire  last_shift,
   input  wire  r_last_shift,   // Registered last shift
   input  wire  sel_latch,      // Byte select cycle, no register write
   output logic progress,       // Advance microcode
   output logic q_en,           // Sample ALU into Q
   output logic rf_we           // Internal register file write
);

   // Hold microcode while shifting or waiting on the bus
   assign progress = ((~shift_repeat | last_shift | r_last_shift) & ~bus_busy)
                   | bus_error;

   // Q freezes on the last shift and while the bus is busy
   assign q_en = (q_load | q_read) & ~last_shift & ~bus_busy;

   // Mostly on, but not while selecting lanes, writing out, or holding a zero shift
   assign rf_we = core_running & ~(sel_latch | bus_we | r_last_shift);

endmodule

`default_nettype wire

//--- hw/progress_ctrl.sv
/*
 * Bus-access progress controller
 * Decode, bus cycle and microcode progress for a small RISC-V core
 */
`timescale 1ns/1ps
`default_nettype none

module progress_ctrl (
   input  wire                    clk,
   input  wire                    RST_I,
   input  wire                    core_running,
   input  wire                    bus_ack,
   input  wire                    sysreg_ack,
   input  wire                    sram_ack,
   input  wire                    bus_error,
   input  progress_pkg::addr_t    addr,
   input  progress_pkg::wsel_t    wsel,
   input  wire                    sel_latch,
   input  wire                    word_store,
   input  wire                    stb_req,
   input  wire                    we_req,
   input  wire                    we_hold,
   input  wire                    q_load,
   input  wire                    q_read,
   input  wire                    shift_repeat,
   input  wire                    last_shift,
   input  wire                    r_last_shift,
   output progress_pkg::bytesel_t byte_sel,
   output progress_pkg::bytesel_t byte_mask,
   output logic                   bus_stb,
   output logic                   sram_stb,
   output logic                   bus_we,
   output logic                   ctrlreg_we,
   output logic                   qack,
   output logic                   progress,
   output logic                   q_en,
   output logic                   rf_we
);
   logic bus_busy;   // Either strobe high

   access_if acc ();  // Decode results

   access_decode u_decode (
      .clk(clk), .RST_I(RST_I), .core_running(core_running),
      .addr(addr), .wsel(wsel), .sel_latch(sel_latch), .word_store(word_store),
      .byte_sel(byte_sel), .byte_mask(byte_mask), .acc(acc.decode)
   );

   bus_cycle u_cycle (
      .clk(clk), .RST_I(RST_I), .bus_ack(bus_ack), .sysreg_ack(sysreg_ack),
      .sram_ack(sram_ack), .bus_error(bus_error), .stb_req(stb_req),
      .we_req(we_req), .we_hold(we_hold), .acc(acc.cycle),
      .bus_stb(bus_stb), .sram_stb(sram_stb), .bus_we(bus_we),
      .ctrlreg_we(ctrlreg_we), .qack(qack), .bus_busy(bus_busy)
   );

   ucode_progress u_progress (
      .core_running(core_running), .bus_busy(bus_busy), .bus_we(bus_we),
      .bus_error(bus_error), .q_load(q_load), .q_read(q_read),
      .shift_repeat(shift_repeat), .last_shift(last_shift),
      .r_last_shift(r_last_shift), .sel_latch(sel_latch),
      .progress(progress), .q_en(q_en), .rf_we(rf_we)
   );

endmodule

`default_nettype wire

//--- bench/tb_progress_ctrl.sv
/*
 * Testbench for the bus-access progress controller
 * Directed tests of byte selects, strobes, write enables and ack qualification
 */
`timescale 1ns/1ps
`default_nettype none

module tb_progress_ctrl;
   import progress_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;
   // Reset, byte selects, two I/O accesses with up to 7 wait cycles, SRAM, writes, held ack
   localparam int TEST_CYCLES  = RESET_CYCLES + 34 + 2 * 16 + 24 + 16 + 22;
   localparam int LIMIT_CYCLES = 2 * TEST_CYCLES;   // Generous margin

   logic     clk = 1'b0;
   logic     RST_I, core_running, bus_ack, sysreg_ack, sram_ack, bus_error;
   addr_t    addr;
   wsel_t    wsel;
   logic     sel_latch, word_store, stb_req, we_req, we_hold;
   logic     q_load, q_read, shift_repeat, last_shift, r_last_shift;
   bytesel_t byte_sel, byte_mask;
   logic     bus_stb, sram_stb, bus_we, ctrlreg_we, qack, progress, q_en, rf_we;

   int         errors = 0;
   int         checks = 0;
   string      test_name;
   logic [7:0] lfsr = 8'd75;   // Ack delay source

   always #(CLK_PERIOD / 2) clk = ~clk;

   progress_ctrl UUT (.*);

   // 8 bit Galois LFSR, taps for x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   task automatic random_bits(input int count, output logic [7:0] value);
      value = 8'd0;
      for (int i = 0; i < count; i++) begin
         lfsr  = lfsr_step(lfsr);
         value = {value[6:0], lfsr[0]};   // One step per bit taken
      end
   endtask

   // Lane table: halfword at offset 0 or 2, one-hot byte, all lanes otherwise
   function automatic bytesel_t lane_pattern(input wsel_t w, input logic [1:0] off);
      case (w)
         4'b0001: lane_pattern = (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b1111;
         4'b0010: lane_pattern = {off == 2'd3, off == 2'd2, off == 2'd1, off == 2'd0};
         default: lane_pattern = 4'b1111;
      endcase
   endfunction

   task automatic check(input string what, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      end
   endtask

   task automatic check_bus(input logic stb, input logic sstb, input logic prog,
                            input logic qen);
      check("bus_stb", stb, bus_stb);
      check("sram_stb", sstb, sram_stb);
      check("progress", prog, progress);
      check("q_en", qen, q_en);
   endtask

   // Inputs change a little after the rising edge, checks run at the falling edge
   task automatic next_cycle;
      @(posedge clk);
      #5;
   endtask

   task automatic reset_state;
      test_name = "reset_state";
      @(negedge clk);
      check_bus(1'b0, 1'b0, 1'b1, 1'b0);
      check("bus_we", 1'b0, bus_we);
      check("ctrlreg_we", 1'b0, ctrlreg_we);
      check("byte_sel", 4'b0000, byte_sel);
      check("byte_mask", 4'b1111, byte_mask);
   endtask

   task automatic byte_selects;
      wsel_t    codes [4];
      bytesel_t lanes;
      bytesel_t mask;
      test_name = "byte_selects";
      codes = '{4'b0000, WSEL_HALF, WSEL_BYTE, 4'b0100};   // Word, half, byte, unused
      foreach (codes[c]) begin
         for (int off = 0; off < 4; off++) begin
            next_cycle;
            addr      = 32'h8000_0000 + 32'(off);
            wsel      = codes[c];
            sel_latch = 1'b1;
            lanes     = lane_pattern(codes[c], off[1:0]);
            mask      = ~lanes;
            @(negedge clk);
            check("rf_we", 1'b0, rf_we);   // No register write while latching
            next_cycle;
            sel_latch = 1'b0;
            @(negedge clk);
            check("byte_sel", lanes, byte_sel);
            check("byte_mask", mask, byte_mask);
            check("rf_we", 1'b1, rf_we);
         end
      end
   endtask

   task automatic io_access;
      logic [7:0] delay;
      test_name = "io_access";
      random_bits(3, delay);   // 0 to 7 wait cycles
      next_cycle;
      addr    = 32'h4000_0010;
      stb_req = 1'b1;
      q_load  = 1'b1;
      @(negedge clk);
      check_bus(1'b0, 1'b0, 1'b1, 1'b1);   // Strobe comes on the next edge
      next_cycle;
      stb_req = 1'b0;
      @(negedge clk);
      check_bus(1'b1, 1'b0, 1'b0, 1'b0);
      repeat (delay) begin
         next_cycle;
         @(negedge clk);
         check_bus(1'b1, 1'b0, 1'b0, 1'b0);   // Held while slave is slow
         check("qack", 1'b0, qack);
      end
      next_cycle;
      bus_ack = 1'b1;
      @(negedge clk);
      check("qack", 1'b1, qack);
      check_bus(1'b1, 1'b0, 1'b0, 1'b0);
      next_cycle;
      bus_ack = 1'b0;
      @(negedge clk);
      check_bus(1'b0, 1'b0, 1'b1, 1'b1);   // Access over
      next_cycle;
      shift_repeat = 1'b1;
      @(negedge clk);
      check("progress", 1'b0, progress);   // Repeating shift stalls
      next_cycle;
      last_shift = 1'b1;
      @(negedge clk);
      check("progress", 1'b1, progress);
      check("q_en", 1'b0, q_en);          // Q frozen on last shift
      next_cycle;
      shift_repeat = 1'b0;
      last_shift   = 1'b0;
      q_load       = 1'b0;
   endtask

   task automatic sram_access;
      logic [7:0] delay;
      test_name = "sram_access";
      random_bits(3, delay);
      next_cycle;
      addr       = 32'h8000_0100;
      word_store = 1'b1;   // Aligned word store is fine
      stb_req    = 1'b1;
      q_read     = 1'b1;   // Q read held off while busy
      next_cycle;
      stb_req = 1'b0;
      @(negedge clk);
      check_bus(1'b0, 1'b1, 1'b0, 1'b0);
      repeat (delay) begin
         next_cycle;
         @(negedge clk);
         check("sram_stb", 1'b1, sram_stb);
      end
      next_cycle;
      sram_ack = 1'b1;
      @(negedge clk);
      check("sram_stb", 1'b1, sram_stb);
      next_cycle;
      sram_ack = 1'b0;
      @(negedge clk);
      check_bus(1'b0, 1'b0, 1'b1, 1'b1);   // Q reads again once idle
      next_cycle;
      addr    = 32'h8000_0102;   // Misaligned word store
      stb_req = 1'b1;
      we_req  = 1'b1;
      q_read  = 1'b0;
      next_cycle;
      stb_req    = 1'b0;
      we_req     = 1'b0;
      word_store = 1'b0;
      @(negedge clk);
      check("sram_stb", 1'b0, sram_stb);
      check("bus_we", 1'b0, bus_we);
      next_cycle;
      addr    = 32'h8000_0100;
      stb_req = 1'b1;
      next_cycle;
      stb_req = 1'b0;
      @(negedge clk);
      check("sram_stb", 1'b1, sram_stb);
      next_cycle;
      bus_error = 1'b1;
      @(negedge clk);
      check_bus(1'b0, 1'b1, 1'b1, 1'b0);   // Error forces progress, strobe drops at edge
      next_cycle;
      bus_error = 1'b0;
      @(negedge clk);
      check_bus(1'b0, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic write_enables;
      test_name = "write_enables";
      next_cycle;
      addr   = 32'h2000_0004;   // Control register
      we_req = 1'b1;
      next_cycle;
      we_req = 1'b0;
      @(negedge clk);
      check("ctrlreg_we", 1'b1, ctrlreg_we);
      check("bus_we", 1'b0, bus_we);
      check("rf_we", 1'b1, rf_we);
      next_cycle;
      we_hold = 1'b0;
      @(negedge clk);
      check("ctrlreg_we", 1'b1, ctrlreg_we);   // Clears on the following edge
      next_cycle;
      we_hold = 1'b1;
      @(negedge clk);
      check("ctrlreg_we", 1'b0, ctrlreg_we);
      next_cycle;
      addr   = 32'h4000_0000;
      we_req = 1'b1;
      next_cycle;
      addr   = 32'h8000_0000;
      @(negedge clk);
      check("bus_we", 1'b1, bus_we);         // I/O write
      check("ctrlreg_we", 1'b0, ctrlreg_we);
      check("rf_we", 1'b0, rf_we);
      next_cycle;
      we_req  = 1'b0;
      we_hold = 1'b0;
      @(negedge clk);
      check("bus_we", 1'b1, bus_we);         // SRAM write loaded
      next_cycle;
      we_hold      = 1'b1;
      r_last_shift = 1'b1;
      @(negedge clk);
      check("bus_we", 1'b0, bus_we);
      check("rf_we", 1'b0, rf_we);           // Registered last shift blocks write
      next_cycle;
      r_last_shift = 1'b0;
      core_running = 1'b0;
      @(negedge clk);
      check("rf_we", 1'b0, rf_we);
      next_cycle;
      core_running = 1'b1;
   endtask

   task automatic held_ack;
      test_name = "held_ack";
      next_cycle;
      addr    = 32'h4000_0000;
      bus_ack = 1'b1;   // Slave holds ack with no strobe
      @(negedge clk);
      check("qack", 1'b0, qack);
      next_cycle;
      stb_req = 1'b1;
      @(negedge clk);
      check("qack", 1'b0, qack);
      next_cycle;
      stb_req = 1'b0;
      @(negedge clk);
      check("bus_stb", 1'b1, bus_stb);
      check("qack", 1'b1, qack);             // Strobe acknowledges itself
      next_cycle;
      @(negedge clk);
      check("bus_stb", 1'b0, bus_stb);
      check("qack", 1'b0, qack);
      next_cycle;
      sysreg_ack = 1'b1;
      @(negedge clk);
      check("qack", 1'b1, qack);             // System register ack always counts
      next_cycle;
      sysreg_ack = 1'b0;
      bus_ack    = 1'b0;
      stb_req    = 1'b1;
      next_cycle;
      stb_req = 1'b0;
      @(negedge clk);
      check("bus_stb", 1'b1, bus_stb);
      check("qack", 1'b0, qack);             // Normal qualification again
      next_cycle;
      bus_ack = 1'b1;
      @(negedge clk);
      check("qack", 1'b1, qack);
      next_cycle;
      bus_ack = 1'b0;
      @(negedge clk);
      check("bus_stb", 1'b0, bus_stb);
      next_cycle;
      sysreg_ack = 1'b1;
      @(negedge clk);
      check("qack", 1'b1, qack);
      next_cycle;
      sysreg_ack = 1'b0;
   endtask

   // Watchdog
   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d clock cycles", LIMIT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      RST_I        = 1'b1;
      core_running = 1'b0;
      bus_ack      = 1'b0;
      sysreg_ack   = 1'b0;
      sram_ack     = 1'b0;
      bus_error    = 1'b0;
      addr         = '0;
      wsel         = '0;
      sel_latch    = 1'b0;
      word_store   = 1'b0;
      stb_req      = 1'b0;
      we_req       = 1'b0;
      we_hold      = 1'b0;
      q_load       = 1'b0;
      q_read       = 1'b0;
      shift_repeat = 1'b0;
      last_shift   = 1'b0;
      r_last_shift = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #5;
      RST_I        = 1'b0;
      core_running = 1'b1;
      we_hold      = 1'b1;
      reset_state;
      byte_selects;
      io_access;
      io_access;   // Second delay from the LFSR
      sram_access;
      write_enables;
      held_ack;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
hw/progress_pkg.sv
hw/access_if.sv
hw/access_decode.sv
hw/ack_qualify.sv
hw/bus_cycle.sv
hw/ucode_progress.sv
hw/progress_ctrl.sv
bench/tb_progress_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the progress controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_progress_ctrl \
   -f filelist.f -o tb_progress_ctrl
./obj_dir/tb_progress_ctrl | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
